/* hw/ellipse_pkg.sv */
// ########################################
// coordinate width default, quadrant codes
// and control phase codes
// ########################################

package ellipse_pkg;

  // default signed coordinate width
  localparam int default_coord_bits = 12;

  // quadrant select, sign of the x and y offsets
  localparam logic [1:0] quad_pp = 2'd0;  // +x +y
  localparam logic [1:0] quad_np = 2'd1;  // -x +y
  localparam logic [1:0] quad_pn = 2'd2;  // +x -y
  localparam logic [1:0] quad_nn = 2'd3;  // -x -y

  // control phase codes
  localparam int phase_bits = 3;

  localparam logic [phase_bits-1:0] phase_idle  = 3'd0;  // waiting for run
  localparam logic [phase_bits-1:0] phase_setup = 3'd1;  // multiplier sequence
  localparam logic [phase_bits-1:0] phase_arc   = 3'd2;  // midpoint octant
  localparam logic [phase_bits-1:0] phase_flat  = 3'd3;  // flat row only
  localparam logic [phase_bits-1:0] phase_point = 3'd4;  // zero radius, center pixel

endpackage

/* hw/ellipse_control.sv */
// ########################################
// job sequencing, octant swap, pause stall
// ########################################

module ellipse_control #(
  parameter int coord_bits = 12
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               run,
  input  logic [1:0]                         quadrant,
  input  logic                               fill,
  input  logic                               pause,
  input  logic signed [coord_bits-1:0]       center_x,
  input  logic signed [coord_bits-1:0]       center_y,
  input  logic signed [coord_bits-1:0]       radius_x,
  input  logic signed [coord_bits-1:0]       radius_y,
  input  logic                               setup_done,
  input  logic                               octant_done,
  input  logic                               pixel_pending,
  output logic                               busy,
  output logic                               complete,
  output logic                               advance,
  output logic [ellipse_pkg::phase_bits-1:0] phase,
  output logic                               swapped,
  output logic [1:0]                         quad_sel,
  output logic                               fill_sel,
  output logic signed [coord_bits-1:0]       oct_center_x,
  output logic signed [coord_bits-1:0]       oct_center_y,
  output logic signed [coord_bits-1:0]       oct_radius_x,
  output logic signed [coord_bits-1:0]       oct_radius_y
);

  logic busy_int;  // registered part of busy

  assign advance = !(pause && pixel_pending);  // hold only when a pixel waits
  assign busy    = busy_int || run;            // rises with run at once

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy_int <= 1'b0;
      complete <= 1'b0;
      phase    <= ellipse_pkg::phase_idle;
      swapped  <= 1'b0;
      quad_sel <= 2'd0;
      fill_sel <= 1'b0;
    end else if (advance) begin
      complete <= 1'b0;                      // one cycle pulse
      if (complete) busy_int <= 1'b0;        // busy drops the cycle after
      case (phase)
        ellipse_pkg::phase_idle: begin
          if (run && !busy_int) begin
            busy_int     <= 1'b1;
            quad_sel     <= quadrant;
            fill_sel     <= fill;
            swapped      <= 1'b0;
            oct_center_x <= center_x;
            oct_center_y <= center_y;
            oct_radius_x <= radius_x;
            oct_radius_y <= radius_y;
            if (radius_x == '0 && radius_y == '0) phase <= ellipse_pkg::phase_point;
            else                                  phase <= ellipse_pkg::phase_setup;
          end
        end
        ellipse_pkg::phase_setup: begin
          if (setup_done) begin
            // narrow x radius has no arc, only the flat row
            if (oct_radius_x < 2) phase <= ellipse_pkg::phase_flat;
            else                  phase <= ellipse_pkg::phase_arc;
          end
        end
        default: begin  // arc, flat and point end on octant_done
          if (octant_done) begin
            if (swapped || phase == ellipse_pkg::phase_point) begin
              complete <= 1'b1;
              phase    <= ellipse_pkg::phase_idle;
            end else begin
              swapped      <= 1'b1;          // second octant, x and y roles exchanged
              oct_center_x <= oct_center_y;
              oct_center_y <= oct_center_x;
              oct_radius_x <= oct_radius_y;
              oct_radius_y <= oct_radius_x;
              phase        <= ellipse_pkg::phase_setup;
            end
          end
        end
      endcase
    end
  end

endmodule

/* hw/ellipse_setup.sv */
// ########################################
// radius squares and initial decision terms
// ########################################

module ellipse_setup #(
  parameter int coord_bits = 12
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    advance,
  input  logic [ellipse_pkg::phase_bits-1:0]      phase,
  input  logic signed [coord_bits-1:0]            oct_radius_x,
  input  logic signed [coord_bits-1:0]            oct_radius_y,
  output logic                                    setup_done,
  output logic [2*(coord_bits-1)-1:0]             rx2,
  output logic [2*(coord_bits-1)-1:0]             ry2,
  output logic signed [3*(coord_bits-1)+1:0]      p_init,
  output logic signed [3*(coord_bits-1)+1:0]      py_init
);

  localparam int rad_bits = coord_bits - 1;
  localparam int dec_bits = 3 * rad_bits + 2;

  logic [2:0]               step;    // sequence position inside phase_setup
  logic [rad_bits-1:0]      mult_a;  // narrow operand
  logic [2*rad_bits-1:0]    mult_b;  // wide operand
  logic [3*rad_bits-1:0]    mult_y;  // registered product
  logic signed [dec_bits-1:0] acc;   // running sum for p_init
  logic signed [dec_bits-1:0] prod_w;

  assign prod_w = signed'({2'b00, mult_y});  // product widened, always positive

  // shared multiplier, one register stage after the operand registers
  always_ff @(posedge clk) begin
    if (advance) mult_y <= mult_a * mult_b;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step       <= 3'd0;
      setup_done <= 1'b0;
    end else if (advance) begin
      setup_done <= 1'b0;
      if (phase != ellipse_pkg::phase_setup) step <= 3'd0;
      else if (step != 3'd5) begin
        step <= step + 3'd1;
        if (step == 3'd4) setup_done <= 1'b1;  // results valid from next cycle
      end
    end
  end

  // operand feed and result capture, no reset needed on payload
  always_ff @(posedge clk) begin
    if (advance && phase == ellipse_pkg::phase_setup) begin
      case (step)
        3'd0: begin
          mult_a <= oct_radius_x[rad_bits-1:0];  // rx * rx
          mult_b <= {{rad_bits{1'b0}}, oct_radius_x[rad_bits-1:0]};
        end
        3'd1: begin
          mult_a <= oct_radius_y[rad_bits-1:0];  // ry * ry
          mult_b <= {{rad_bits{1'b0}}, oct_radius_y[rad_bits-1:0]};
        end
        3'd2: begin
          rx2    <= mult_y[2*rad_bits-1:0];
          mult_a <= oct_radius_y[rad_bits-1:0];  // ry * rx2
          mult_b <= mult_y[2*rad_bits-1:0];
          acc    <= (prod_w + 2) >>> 2;          // rounded quarter of rx2
        end
        3'd3: begin
          ry2 <= mult_y[2*rad_bits-1:0];
          acc <= acc + prod_w;                    // + ry2
        end
        3'd4: begin
          p_init  <= acc - prod_w;                // - ry*rx2
          py_init <= prod_w <<< 1;                // 2*ry*rx2
        end
        default: ;
      endcase
    end
  end

endmodule

/* hw/arc_stepper.sv */
// ########################################
// midpoint octant loop and flat row
// ########################################

module arc_stepper #(
  parameter int coord_bits = 12
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               advance,
  input  logic [ellipse_pkg::phase_bits-1:0] phase,
  input  logic                               swapped,
  input  logic                               fill_sel,
  input  logic                               fill_busy,
  input  logic                               setup_done,
  input  logic signed [coord_bits-1:0]       oct_radius_x,
  input  logic signed [coord_bits-1:0]       oct_radius_y,
  input  logic [2*(coord_bits-1)-1:0]        rx2,
  input  logic [2*(coord_bits-1)-1:0]        ry2,
  input  logic signed [3*(coord_bits-1)+1:0] p_init,
  input  logic signed [3*(coord_bits-1)+1:0] py_init,
  output logic signed [coord_bits-1:0]       step_x,
  output logic signed [coord_bits-1:0]       step_y,
  output logic                               step_valid,
  output logic                               y_stepped,
  output logic                               octant_done,
  output logic                               pixel_pending
);

  localparam int rad_bits = coord_bits - 1;
  localparam int dec_bits = 3 * rad_bits + 2;

  logic signed [coord_bits-1:0] x, y;
  logic signed [dec_bits-1:0]   p, px, py;
  logic signed [dec_bits-1:0]   rx2_w, ry2_w, px_n, py_n;
  logic arc_over;    // px passed py, remainder is flat row
  logic draw_flat;   // y cleared, flat row being drawn
  logic point_sent;  // center pixel issued
  logic go;          // stepper may move this cycle
  logic flat_mode, arc_step, flat_more;

  assign rx2_w = signed'({{(dec_bits-2*rad_bits){1'b0}}, rx2});
  assign ry2_w = signed'({{(dec_bits-2*rad_bits){1'b0}}, ry2});
  assign px_n  = px + (ry2_w <<< 1);
  assign py_n  = py - (rx2_w <<< 1);

  assign go        = advance && !fill_busy;
  assign flat_mode = phase == ellipse_pkg::phase_flat ||
                     (phase == ellipse_pkg::phase_arc && arc_over);
  assign arc_step  = phase == ellipse_pkg::phase_arc && !arc_over && px <= py;
  assign flat_more = (y < 2 || draw_flat) && x <= oct_radius_x;

  assign step_x = x;
  assign step_y = y;
  always_comb begin
    step_valid  = 1'b0;
    octant_done = 1'b0;
    if (go) begin
      if (phase == ellipse_pkg::phase_point) begin
        step_valid  = !point_sent;
        octant_done = point_sent;
      end else if (arc_step) begin
        step_valid = 1'b1;
      end else if (flat_mode) begin
        step_valid  = flat_more && draw_flat;
        octant_done = !flat_more;
      end
    end
  end
  // a new screen row starts: every step when swapped, on a y step otherwise
  assign y_stepped = fill_sel && (swapped || (arc_step && p > 0));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixel_pending <= 1'b0;
      arc_over      <= 1'b0;
      draw_flat     <= 1'b0;
      point_sent    <= 1'b0;
    end else if (advance) begin
      pixel_pending <= step_valid || fill_busy;  // mirrors the mapper output register
      if (phase == ellipse_pkg::phase_idle) point_sent <= 1'b0;
      else if (phase == ellipse_pkg::phase_point && go) point_sent <= 1'b1;
      if (setup_done) begin
        arc_over  <= 1'b0;
        draw_flat <= 1'b0;
      end else if (go && phase == ellipse_pkg::phase_arc && !arc_over && !arc_step) begin
        arc_over <= 1'b1;
      end else if (go && flat_mode && flat_more) begin
        draw_flat <= 1'b1;
      end
    end
  end

  // coordinate and decision registers
  always_ff @(posedge clk) begin
    if (advance) begin
      if (phase == ellipse_pkg::phase_idle) begin
        x <= '0;
        y <= '0;
      end else if (setup_done) begin
        x  <= '0;                          // start at top of the arc
        y  <= oct_radius_y;
        p  <= p_init;
        px <= '0;
        py <= py_init;
      end else if (go && arc_step) begin
        x  <= x + 1'b1;
        px <= px_n;
        if (p <= 0) begin
          p <= p + ry2_w + px_n;
        end else begin
          y  <= y - 1'b1;
          py <= py_n;
          p  <= p + ry2_w + px_n - py_n;
        end
      end else if (go && flat_mode && flat_more) begin
        y <= '0;                           // drop to the center row first
        if (draw_flat) x <= x + 1'b1;
      end
    end
  end

endmodule

/* hw/quadrant_mapper.sv */
// ########################################
// quadrant mirror, axis swap, fill run
// ########################################

module quadrant_mapper #(
  parameter int coord_bits = 12
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         advance,
  input  logic                         swapped,
  input  logic [1:0]                   quad_sel,
  input  logic                         fill_sel,
  input  logic signed [coord_bits-1:0] step_x,
  input  logic signed [coord_bits-1:0] step_y,
  input  logic                         step_valid,
  input  logic                         y_stepped,
  input  logic signed [coord_bits-1:0] oct_center_x,
  input  logic signed [coord_bits-1:0] oct_center_y,
  output logic signed [coord_bits-1:0] x_out,
  output logic signed [coord_bits-1:0] y_out,
  output logic                         pixel_valid,
  output logic                         fill_busy
);

  logic signed [coord_bits-1:0] dx, dy;      // screen offsets before mirroring
  logic signed [coord_bits-1:0] cx, cy;      // screen center
  logic signed [coord_bits-1:0] x_new, y_new, x_walk;
  logic neg_x, neg_y;
  logic valid_r;  // output register holds a pixel
  logic walking;  // horizontal fill run in progress

  assign neg_x = quad_sel == ellipse_pkg::quad_np || quad_sel == ellipse_pkg::quad_nn;
  assign neg_y = quad_sel == ellipse_pkg::quad_pn || quad_sel == ellipse_pkg::quad_nn;

  // second octant has x and y exchanged, centers already swapped by control
  assign dx = swapped ? step_y : step_x;
  assign dy = swapped ? step_x : step_y;
  assign cx = swapped ? oct_center_y : oct_center_x;
  assign cy = swapped ? oct_center_x : oct_center_y;

  assign x_new  = neg_x ? cx - dx : cx + dx;
  assign y_new  = neg_y ? cy - dy : cy + dy;
  assign x_walk = (x_out > cx) ? x_out - 1'b1 : x_out + 1'b1;  // one column toward center

  assign pixel_valid = valid_r && advance;  // low while the pixel is held
  assign fill_busy   = walking;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_r <= 1'b0;
      walking <= 1'b0;
    end else if (advance) begin
      valid_r <= step_valid || walking;
      if (walking)         walking <= x_walk != cx;
      else if (step_valid) walking <= fill_sel && y_stepped && dx != '0;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if (walking) begin
        x_out <= x_walk;                    // row stays, column moves
      end else if (step_valid) begin
        x_out <= x_new;
        y_out <= y_new;
      end
    end
  end

endmodule

/* hw/ellipse_top.sv */
// ########################################
// ellipse quadrant rasterizer top level
// ########################################

module ellipse_top #(
  parameter int coord_bits = ellipse_pkg::default_coord_bits
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         run,       // start a job while not busy
  input  logic [1:0]                   quadrant,
  input  logic                         fill,      // horizontal fill toward center
  input  logic                         pause,
  input  logic signed [coord_bits-1:0] center_x,
  input  logic signed [coord_bits-1:0] center_y,
  input  logic signed [coord_bits-1:0] radius_x,
  input  logic signed [coord_bits-1:0] radius_y,
  output logic                         busy,
  output logic                         complete,
  output logic                         pixel_valid,
  output logic signed [coord_bits-1:0] x_out,
  output logic signed [coord_bits-1:0] y_out
);

  localparam int rad_bits = coord_bits - 1;
  localparam int dec_bits = 3 * rad_bits + 2;

  logic                                  advance;
  logic [ellipse_pkg::phase_bits-1:0]    phase;
  logic                                  swapped, fill_sel;
  logic [1:0]                            quad_sel;
  logic signed [coord_bits-1:0]          oct_center_x, oct_center_y;
  logic signed [coord_bits-1:0]          oct_radius_x, oct_radius_y;
  logic                                  setup_done, octant_done, pixel_pending;
  logic [2*rad_bits-1:0]                 rx2, ry2;
  logic signed [dec_bits-1:0]            p_init, py_init;
  logic signed [coord_bits-1:0]          step_x, step_y;
  logic                                  step_valid, y_stepped, fill_busy;

  ellipse_control #(.coord_bits(coord_bits)) u_control (
    .clk, .reset, .run, .quadrant, .fill, .pause, .center_x, .center_y,
    .radius_x, .radius_y, .setup_done, .octant_done, .pixel_pending,
    .busy, .complete, .advance, .phase, .swapped, .quad_sel, .fill_sel,
    .oct_center_x, .oct_center_y, .oct_radius_x, .oct_radius_y
  );

  ellipse_setup #(.coord_bits(coord_bits)) u_setup (
    .clk, .reset, .advance, .phase, .oct_radius_x, .oct_radius_y,
    .setup_done, .rx2, .ry2, .p_init, .py_init
  );

  arc_stepper #(.coord_bits(coord_bits)) u_stepper (
    .clk, .reset, .advance, .phase, .swapped, .fill_sel, .fill_busy, .setup_done,
    .oct_radius_x, .oct_radius_y, .rx2, .ry2, .p_init, .py_init,
    .step_x, .step_y, .step_valid, .y_stepped, .octant_done, .pixel_pending
  );

  quadrant_mapper #(.coord_bits(coord_bits)) u_mapper (
    .clk, .reset, .advance, .swapped, .quad_sel, .fill_sel, .step_x, .step_y,
    .step_valid, .y_stepped, .oct_center_x, .oct_center_y,
    .x_out, .y_out, .pixel_valid, .fill_busy
  );

endmodule

/* tests/ellipse_tb.sv */
// ########################################
// ellipse rasterizer testbench, reference
// pixel sets, checks and watchdog
// ########################################

module ellipse_tb;

  localparam int coord_bits = 12;
  localparam int max_r      = 40;
  localparam int n_random   = 8;
  localparam int n_jobs     = 4 + 2 * n_random;  // fixed jobs, random jobs run twice

  logic clk = 1'b0;
  logic reset, run, fill, pause;
  logic [1:0] quadrant;
  logic signed [coord_bits-1:0] center_x, center_y, radius_x, radius_y;
  logic busy, complete, pixel_valid;
  logic signed [coord_bits-1:0] x_out, y_out;

  int errors = 0;
  int checks = 0;
  int cycle  = 0;
  int job_cx, job_cy, job_rx, job_ry;
  logic [1:0] job_quad;
  bit job_open, job_done, complete_prev;
  int accept_cycle, first_cycle, done_cycle, complete_cnt;
  bit got_map [0:63][0:63];               // offsets seen, [dx][dy]
  bit ref_map [0:63][0:63];               // offsets from the reference outline
  logic [2*coord_bits-1:0] seq_q[$];      // pixels of the current job in order
  logic [2*coord_bits-1:0] ref_seq[$];    // same command, unpaused

  ellipse_top #(.coord_bits(coord_bits)) uut (
    .clk, .reset, .run, .quadrant, .fill, .pause, .center_x, .center_y,
    .radius_x, .radius_y, .busy, .complete, .pixel_valid, .x_out, .y_out
  );

  always #2 clk = ~clk;

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Fail at %0t: %s", $time, msg);
    end
  endtask

  // a held pixel must not be presented
  assert property (@(posedge clk) disable iff (reset) !(pixel_valid && pause))
    else begin
      errors++;
      $display("Fail at %0t: pixel_valid high while pause high", $time);
    end

  always @(posedge clk) begin
    int ox, oy;
    if (!reset) begin
      cycle++;
      if (run && !job_open) begin
        job_open     = 1'b1;  // run taken while idle
        accept_cycle = cycle;
      end
      if (job_open) check(busy, "busy low while a job is running");
      if (pixel_valid) begin
        ox = int'(x_out) - job_cx;
        oy = int'(y_out) - job_cy;
        if (job_quad == ellipse_pkg::quad_np || job_quad == ellipse_pkg::quad_nn) ox = -ox;
        if (job_quad == ellipse_pkg::quad_pn || job_quad == ellipse_pkg::quad_nn) oy = -oy;
        check(ox >= 0 && oy >= 0 && ox <= job_rx && oy <= job_ry,
              $sformatf("pixel (%0d,%0d) outside quadrant %0d or radii", x_out, y_out, job_quad));
        if (ox >= 0 && oy >= 0 && ox < 64 && oy < 64) got_map[ox][oy] = 1'b1;
        if (seq_q.size() == 0) first_cycle = cycle;
        seq_q.push_back({x_out, y_out});
      end
      if (complete_prev) check(!complete && !busy, "complete wider than one cycle or busy held");
      if (complete) begin
        complete_cnt++;
        done_cycle = cycle;
        job_open   = 1'b0;
        job_done   = 1'b1;
      end
      complete_prev = complete;
    end
  end

  function automatic void mark(input int x, input int y, input bit swap);
    int dx, dy;
    dx = swap ? y : x;  // second octant has the axes exchanged
    dy = swap ? x : y;
    if (dx >= 0 && dy >= 0 && dx < 64 && dy < 64) ref_map[dx][dy] = 1'b1;
  endfunction

  // midpoint octant from (0, b), then the flat row on y = 0 if the arc ends low
  function automatic void trace_octant(input int a, input int b, input bit swap);
    longint a2, b2, p, px, py;
    int x, y;
    a2 = a * a;
    b2 = b * b;
    p  = (a2 + 2) / 4 + b2 - b * a2;  // quarter of a2 rounded
    px = 0;
    py = 2 * b * a2;
    x  = 0;
    y  = b;
    if (a >= 2) begin
      while (px <= py) begin
        mark(x, y, swap);
        x++;
        px += 2 * b2;
        if (p <= 0) begin
          p += b2 + px;
        end else begin
          y--;
          py -= 2 * a2;
          p += b2 + px - py;
        end
      end
    end
    if (y < 2) begin
      while (x <= a) begin
        mark(x, 0, swap);
        x++;
      end
    end
  endfunction

  task automatic verify_job(input bit fl, input bit paused);
    int dx, dy, top, diffs;
    check(complete_cnt == 1, $sformatf("%0d complete pulses in one job", complete_cnt));
    if (job_rx == 0 && job_ry == 0) begin
      check(seq_q.size() == 1 && got_map[0][0], "zero radius gave more than the center pixel");
      check(first_cycle - accept_cycle == 2, "zero radius pixel not 2 cycles after run");
      check(done_cycle - accept_cycle == 3, "zero radius complete not 3 cycles after run");
    end else begin
      trace_octant(job_rx, job_ry, 1'b0);
      trace_octant(job_ry, job_rx, 1'b1);
      check(first_cycle - accept_cycle >= 6, "first pixel earlier than 6 cycles after run");
      check(got_map[job_rx][0] && got_map[0][job_ry], "extreme points missing");
      diffs = 0;
      for (dx = 0; dx < 64; dx++) begin
        for (dy = 0; dy < 64; dy++) begin
          if (fl ? (ref_map[dx][dy] && !got_map[dx][dy]) : (ref_map[dx][dy] != got_map[dx][dy]))
            diffs++;
        end
      end
      check(diffs == 0, $sformatf("%0d pixels differ from the reference outline", diffs));
      if (fl) begin
        for (dy = 0; dy <= job_ry; dy++) begin
          top   = -1;
          diffs = 0;
          for (dx = 0; dx < 64; dx++) if (got_map[dx][dy]) top = dx;   // outline column
          for (dx = 0; dx <= top; dx++) if (!got_map[dx][dy]) diffs++;  // gaps in the span
          check(top >= 0 && diffs == 0, $sformatf("fill row %0d not contiguous", dy));
        end
      end
    end
    if (paused) begin
      check(seq_q.size() == ref_seq.size(), "paused run gave a different pixel count");
      diffs = 0;
      for (dx = 0; dx < seq_q.size() && dx < ref_seq.size(); dx++)
        if (seq_q[dx] != ref_seq[dx]) diffs++;
      check(diffs == 0, $sformatf("%0d pixels out of order under pause", diffs));
    end else begin
      ref_seq = seq_q;
    end
  endtask

  task automatic run_job(input int cx, input int cy, input int rx, input int ry,
                         input logic [1:0] quad, input bit fl, input bit paused,
                         input bit poke);
    got_map      = '{default: '{default: 1'b0}};
    ref_map      = '{default: '{default: 1'b0}};
    seq_q.delete();
    job_cx       = cx;
    job_cy       = cy;
    job_rx       = rx;
    job_ry       = ry;
    job_quad     = quad;
    complete_cnt = 0;
    job_done     = 1'b0;
    @(negedge clk);
    center_x = coord_bits'(cx);
    center_y = coord_bits'(cy);
    radius_x = coord_bits'(rx);
    radius_y = coord_bits'(ry);
    quadrant = quad;
    fill     = fl;
    run      = 1'b1;
    @(negedge clk);
    run = 1'b0;
    if (poke) begin
      repeat (3) @(negedge clk);
      run      = 1'b1;                                // ignored, job still busy
      radius_x = coord_bits'($urandom % max_r);
      @(negedge clk);
      run = 1'b0;
    end
    while (!job_done) begin
      @(negedge clk);
      pause = paused && ($urandom % 3 == 0);          // random stall pulses
    end
    pause = 1'b0;
    repeat (3) @(negedge clk);                        // idle gap after complete
    verify_job(fl, paused);
  endtask

  initial begin
    int n, cx, cy, rx, ry;
    logic [1:0] q;
    void'($urandom(32'h97e1_e6ad));
    reset    = 1'b1;
    run      = 1'b0;
    fill     = 1'b0;
    pause    = 1'b0;
    quadrant = 2'd0;
    center_x = '0;
    center_y = '0;
    radius_x = '0;
    radius_y = '0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    run_job(300, -200, 0, 0, ellipse_pkg::quad_pn, 1'b0, 1'b0, 1'b0);  // center pixel only
    run_job(100, -50, 10, 4, ellipse_pkg::quad_pp, 1'b1, 1'b0, 1'b0);
    run_job(0, 0, 10, 10, ellipse_pkg::quad_nn, 1'b1, 1'b0, 1'b0);
    run_job(-700, 500, 40, 3, ellipse_pkg::quad_np, 1'b0, 1'b0, 1'b1);
    for (n = 0; n < n_random; n++) begin
      cx = int'($urandom % 2001) - 1000;
      cy = int'($urandom % 2001) - 1000;
      rx = 2 + int'($urandom % (max_r - 1));
      ry = 2 + int'($urandom % (max_r - 1));
      q  = 2'($urandom);
      run_job(cx, cy, rx, ry, q, 1'b0, 1'b0, n[0]);
      run_job(cx, cy, rx, ry, q, 1'b0, 1'b1, 1'b0);  // same command with stalls
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int limit;
    limit = n_jobs * (8 * (2 * max_r + 2) ** 2 + 50);
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not end within %0d cycles", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* build.f */
hw/ellipse_pkg.sv
hw/ellipse_control.sv
hw/ellipse_setup.sv
hw/arc_stepper.sv
hw/quadrant_mapper.sv
hw/ellipse_top.sv
tests/ellipse_tb.sv

/* Makefile */
TOP = ellipse_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

obj_dir/V$(TOP): build.f hw/*.sv tests/*.sv
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
